//--- order_book.f
+incdir+include
rtl/order_book_pkg.sv
rtl/order_dispatch.sv
rtl/stock_book.sv
rtl/quote_collector.sv
rtl/order_book.sv
test/order_book_checker.sv
test/order_book_tb.sv

//--- test/order_book_tb.sv
// order book testbench with reference model, directed and random orders
// compares status and quotes during every acknowledge phase
`include "order_book_macros.svh"

module order_book_tb;

    localparam int TIMEOUT_CYCLES = 3000;
    localparam int ACK_LATENCY    = 3;
    localparam int RANDOM_ORDERS  = 150;
    localparam int RNG_SEED       = 30;

    logic                       i_clk;
    logic                       i_reset_n;
    logic                       i_req;
    order_book_pkg::order_op_t  i_op;
    order_book_pkg::side_t      i_side;
    order_book_pkg::stock_id_t  i_stock;
    order_book_pkg::order_id_t  i_id;
    order_book_pkg::price_t     i_price;
    order_book_pkg::qty_t       i_qty;
    logic                       o_ack;
    order_book_pkg::status_t    o_status;
    order_book_pkg::price_t     o_best_bid;
    order_book_pkg::price_t     o_best_ask;

    // reference book, indexed by stock, side (0 sell, 1 buy) and slot
    logic                       m_valid [`OB_NUM_STOCKS][2][`OB_BOOK_DEPTH];
    order_book_pkg::order_id_t  m_id    [`OB_NUM_STOCKS][2][`OB_BOOK_DEPTH];
    order_book_pkg::price_t     m_price [`OB_NUM_STOCKS][2][`OB_BOOK_DEPTH];
    order_book_pkg::qty_t       m_qty   [`OB_NUM_STOCKS][2][`OB_BOOK_DEPTH];

    order_book_pkg::status_t    exp_status;
    order_book_pkg::price_t     exp_bid;
    order_book_pkg::price_t     exp_ask;
    string                      test_name;
    int                         orders_sent;
    int                         results_checked;
    int                         cycle_count;
    bit                         ack_seen;

    order_book i_dut (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .i_req      (i_req),
        .i_op       (i_op),
        .i_side     (i_side),
        .i_stock    (i_stock),
        .i_id       (i_id),
        .i_price    (i_price),
        .i_qty      (i_qty),
        .o_ack      (o_ack),
        .o_status   (o_status),
        .o_best_bid (o_best_bid),
        .o_best_ask (o_best_ask)
    );

    bind order_book order_book_checker u_checker (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .i_req      (i_req),
        .o_ack      (o_ack),
        .o_status   (o_status),
        .o_best_bid (o_best_bid),
        .o_best_ask (o_best_ask)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic log_mismatch(input string name, input string field,
                                input logic [63:0] expected, input logic [63:0] actual);
        $display("CHECK FAILED [%s] %s: expected 0x%0h, actual 0x%0h",
                 name, field, expected, actual);
        abort_run();
    endtask

    task automatic raise_error(input string msg);
        $display("%s", msg);
        abort_run();
    endtask

    // applies one order to the reference book and returns the expected result
    function automatic void model_order(
        input  logic [1:0]                  op,
        input  int                          side,
        input  int                          stock,
        input  order_book_pkg::order_id_t   id,
        input  order_book_pkg::price_t      price,
        input  order_book_pkg::qty_t        qty,
        output order_book_pkg::status_t     status,
        output order_book_pkg::price_t      bid,
        output order_book_pkg::price_t      ask
    );
        int slot;
        slot   = -1;
        status = order_book_pkg::OK;
        for (int i = 0; i < `OB_BOOK_DEPTH; i++) begin
            if (slot < 0) begin
                if (op == 2'd0 && !m_valid[stock][side][i]) slot = i;
                if (op != 2'd0 && m_valid[stock][side][i] && m_id[stock][side][i] == id) slot = i;
            end
        end
        case (op)
            2'd0: begin
                if (slot < 0) begin
                    status = order_book_pkg::BOOK_FULL;
                end else begin
                    m_valid[stock][side][slot] = 1'b1;
                    m_id[stock][side][slot]    = id;
                    m_price[stock][side][slot] = price;
                    m_qty[stock][side][slot]   = qty;
                end
            end
            2'd1: begin
                if (slot < 0) status = order_book_pkg::NOT_FOUND;
                else m_valid[stock][side][slot] = 1'b0;
            end
            2'd2: begin
                if (slot < 0) begin
                    status = order_book_pkg::NOT_FOUND;
                end else if (qty > m_qty[stock][side][slot]) begin
                    status = order_book_pkg::OVERFILL;
                end else begin
                    m_qty[stock][side][slot] = m_qty[stock][side][slot] - qty;
                    if (m_qty[stock][side][slot] == 0) m_valid[stock][side][slot] = 1'b0;
                end
            end
            default: status = order_book_pkg::BAD_OP;
        endcase
        // empty bid side quotes 0, empty ask side quotes all ones
        bid = '0;
        ask = '1;
        for (int i = 0; i < `OB_BOOK_DEPTH; i++) begin
            if (m_valid[stock][1][i] && m_price[stock][1][i] > bid) bid = m_price[stock][1][i];
            if (m_valid[stock][0][i] && m_price[stock][0][i] < ask) ask = m_price[stock][0][i];
        end
    endfunction

    // one four-phase transaction, entered and left on a falling edge with o_ack low
    task automatic run_order(input string name, input logic [1:0] op, input int side,
                             input int stock, input order_book_pkg::order_id_t id,
                             input order_book_pkg::price_t price,
                             input order_book_pkg::qty_t qty, input int hold);
        int wait_cycles;
        model_order(op, side, stock, id, price, qty, exp_status, exp_bid, exp_ask);
        test_name = name;
        i_op      = order_book_pkg::order_op_t'(op);
        i_side    = order_book_pkg::side_t'(side);
        i_stock   = order_book_pkg::stock_id_t'(stock);
        i_id      = id;
        i_price   = price;
        i_qty     = qty;
        i_req     = 1'b1;
        orders_sent++;
        wait_cycles = 0;
        do begin
            @(negedge i_clk);
            wait_cycles++;
        end while (!o_ack);
        // the first rising edge after the request is the accepting edge
        assert (wait_cycles - 1 == ACK_LATENCY)
            else log_mismatch(name, "ack latency", ACK_LATENCY, wait_cycles - 1);
        // the host keeps i_req up, so o_ack has to stay up as well
        repeat (hold) begin
            @(negedge i_clk);
            assert (o_ack)
                else raise_error({name, ": o_ack dropped while i_req was still held"});
        end
        i_req = 1'b0;
        @(negedge i_clk);
        assert (!o_ack)
            else raise_error({name, ": o_ack did not fall one cycle after i_req dropped"});
    endtask

    // results are compared on every falling edge of the acknowledge phase
    always @(negedge i_clk) begin
        if (i_reset_n && o_ack) begin
            if (!ack_seen) results_checked++;
            assert (o_status == exp_status)
                else log_mismatch(test_name, "status", exp_status, o_status);
            assert (o_best_bid == exp_bid)
                else log_mismatch(test_name, "best bid", exp_bid, o_best_bid);
            assert (o_best_ask == exp_ask)
                else log_mismatch(test_name, "best ask", exp_ask, o_best_ask);
        end
        ack_seen = o_ack;
    end

    always @(posedge i_clk) begin
        cycle_count++;
        assert (cycle_count < TIMEOUT_CYCLES)
            else raise_error("timeout: the run did not finish within the cycle limit");
    end

    initial begin
        int                         pick;
        logic [1:0]                 op;
        int                         side;
        int                         stock;
        int                         hold;
        order_book_pkg::order_id_t  id;
        order_book_pkg::price_t     price;
        order_book_pkg::qty_t       qty;
        void'($urandom(RNG_SEED));
        i_reset_n       = 1'b0;
        i_req           = 1'b0;
        i_op            = order_book_pkg::ADD;
        i_side          = order_book_pkg::SELL;
        i_stock         = '0;
        i_id            = '0;
        i_price         = '0;
        i_qty           = '0;
        orders_sent     = 0;
        results_checked = 0;
        cycle_count     = 0;
        ack_seen        = 1'b0;
        for (int s = 0; s < `OB_NUM_STOCKS; s++) begin
            for (int d = 0; d < 2; d++) begin
                for (int i = 0; i < `OB_BOOK_DEPTH; i++) begin
                    m_valid[s][d][i] = 1'b0;
                end
            end
        end
        repeat (8) @(negedge i_clk);
        i_reset_n = 1'b1;
        @(negedge i_clk);
        assert (!o_ack) else log_mismatch("reset", "ack", 0, o_ack);
        assert (o_status == order_book_pkg::OK) else log_mismatch("reset", "status", 0, o_status);
        assert (o_best_bid == '0) else log_mismatch("reset", "best bid", 0, o_best_bid);
        assert (o_best_ask == '1)
            else log_mismatch("reset", "best ask", 32'hffff_ffff, o_best_ask);

        // adds on both sides of two stocks
        run_order("add bid 100", 2'd0, 1, 0, 1, 100, 10, 0);
        run_order("add bid 105", 2'd0, 1, 0, 2, 105, 5, 1);
        run_order("add bid 95", 2'd0, 1, 0, 3, 95, 8, 0);
        run_order("add ask 110", 2'd0, 0, 0, 11, 110, 10, 0);
        run_order("add ask 108", 2'd0, 0, 0, 12, 108, 7, 0);
        run_order("add bid other stock", 2'd0, 1, 2, 21, 50, 4, 0);
        run_order("add ask other stock", 2'd0, 0, 2, 22, 60, 4, 0);
        // cancels
        run_order("cancel best bid", 2'd1, 1, 0, 2, 0, 0, 0);
        run_order("cancel best ask", 2'd1, 0, 0, 12, 0, 0, 0);
        run_order("cancel unknown id", 2'd1, 1, 2, 99, 0, 0, 0);
        // executes
        run_order("partial execute", 2'd2, 1, 0, 1, 0, 4, 0);
        run_order("full execute", 2'd2, 1, 0, 1, 0, 6, 0);
        run_order("overfill execute", 2'd2, 0, 0, 11, 0, 50, 0);
        run_order("execute unknown id", 2'd2, 0, 0, 77, 0, 1, 0);
        // capacity of one side
        for (int i = 0; i < `OB_BOOK_DEPTH + 1; i++) begin
            run_order($sformatf("fill ask %0d", i), 2'd0, 0, 3, 31 + i, 120 + i, 3, 0);
        end
        run_order("cancel in full book", 2'd1, 0, 3, 32, 0, 0, 0);
        run_order("add after cancel", 2'd0, 0, 3, 35, 119, 3, 0);
        // invalid opcode, with a delayed release of i_req
        run_order("bad opcode", 2'd3, 1, 0, 1, 200, 1, 3);
        run_order("bad opcode empty stock", 2'd3, 0, 1, 5, 10, 1, 2);

        for (int n = 0; n < RANDOM_ORDERS; n++) begin
            pick = $urandom_range(0, 9);
            if (pick < 5) op = 2'd0;
            else if (pick < 7) op = 2'd1;
            else if (pick < 9) op = 2'd2;
            else op = 2'd3;
            side  = $urandom_range(0, 1);
            stock = $urandom_range(0, `OB_NUM_STOCKS - 1);
            id    = $urandom_range(1, 8);
            price = $urandom_range(90, 110);
            qty   = (op == 2'd2) ? $urandom_range(1, 15) : $urandom_range(1, 20);
            hold  = $urandom_range(0, 2);
            run_order($sformatf("random %0d", n), op, side, stock, id, price, qty, hold);
        end

        if (results_checked == orders_sent) begin
            $display("Testbench passed");
            $finish;
        end else begin
            raise_error("not every order produced an acknowledge phase");
        end
    end

endmodule

//--- test/order_book_checker.sv
// concurrent checks on the host handshake and result stability
module order_book_checker (
    input logic                     i_clk,
    input logic                     i_reset_n,
    input logic                     i_req,
    input logic                     o_ack,
    input order_book_pkg::status_t  o_status,
    input order_book_pkg::price_t   o_best_bid,
    input order_book_pkg::price_t   o_best_ask
);

    // acknowledge only answers a pending request
    ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        $rose(o_ack) |-> $past(i_req))
        else $error("o_ack rose while no request was pending");

    // ack holds as long as the host keeps the request up
    ack_holds: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (o_ack && i_req) |=> o_ack)
        else $error("o_ack dropped while i_req was still high");

    // results may not move during the acknowledge phase
    result_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (o_ack && $past(o_ack)) |->
            ($stable(o_status) && $stable(o_best_bid) && $stable(o_best_ask)))
        else $error("status or quotes changed while o_ack was high");

    ack_low_after_reset: assert property (@(posedge i_clk)
        !i_reset_n |=> !o_ack)
        else $error("o_ack was high in the cycle after reset");

endmodule

//--- rtl/order_book.sv
// order book top level
// dispatcher, one stock book per stock and the result collector
`include "order_book_macros.svh"

module order_book (
    input  logic                        i_clk,
    input  logic                        i_reset_n,
    input  logic                        i_req,
    input  order_book_pkg::order_op_t   i_op,
    input  order_book_pkg::side_t       i_side,
    input  order_book_pkg::stock_id_t   i_stock,
    input  order_book_pkg::order_id_t   i_id,
    input  order_book_pkg::price_t      i_price,
    input  order_book_pkg::qty_t        i_qty,
    output logic                        o_ack,
    output order_book_pkg::status_t     o_status,
    output order_book_pkg::price_t      o_best_bid,
    output order_book_pkg::price_t      o_best_ask
);

    // command buses shared by all stock books
    logic [`OB_NUM_STOCKS-1:0]  cmd_valid;
    order_book_pkg::order_op_t  cmd_op;
    order_book_pkg::side_t      cmd_side;
    order_book_pkg::order_id_t  cmd_id;
    order_book_pkg::price_t     cmd_price;
    order_book_pkg::qty_t       cmd_qty;
    logic                       bad_op;
    order_book_pkg::stock_id_t  sel_stock;
    logic                       result_ready;

    // per-stock results
    logic [`OB_NUM_STOCKS-1:0]  book_done;
    order_book_pkg::status_t    book_status   [`OB_NUM_STOCKS];
    order_book_pkg::price_t     book_best_bid [`OB_NUM_STOCKS];
    order_book_pkg::price_t     book_best_ask [`OB_NUM_STOCKS];

    order_dispatch u_dispatch (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_req          (i_req),
        .i_op           (i_op),
        .i_side         (i_side),
        .i_stock        (i_stock),
        .i_id           (i_id),
        .i_price        (i_price),
        .i_qty          (i_qty),
        .i_result_ready (result_ready),
        .o_ack          (o_ack),
        .o_cmd_valid    (cmd_valid),
        .o_cmd_op       (cmd_op),
        .o_cmd_side     (cmd_side),
        .o_cmd_id       (cmd_id),
        .o_cmd_price    (cmd_price),
        .o_cmd_qty      (cmd_qty),
        .o_bad_op       (bad_op),
        .o_sel_stock    (sel_stock)
    );

    for (genvar s = 0; s < `OB_NUM_STOCKS; s++) begin : g_book
        stock_book #(
            .DEPTH (`OB_BOOK_DEPTH)
        ) u_book (
            .i_clk       (i_clk),
            .i_reset_n   (i_reset_n),
            .i_cmd_valid (cmd_valid[s]),
            .i_cmd_op    (cmd_op),
            .i_cmd_side  (cmd_side),
            .i_cmd_id    (cmd_id),
            .i_cmd_price (cmd_price),
            .i_cmd_qty   (cmd_qty),
            .o_done      (book_done[s]),
            .o_status    (book_status[s]),
            .o_best_bid  (book_best_bid[s]),
            .o_best_ask  (book_best_ask[s])
        );
    end

    quote_collector u_collector (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_done         (book_done),
        .i_status       (book_status),
        .i_best_bid     (book_best_bid),
        .i_best_ask     (book_best_ask),
        .i_bad_op       (bad_op),
        .i_sel_stock    (sel_stock),
        .o_status       (o_status),
        .o_best_bid     (o_best_bid),
        .o_best_ask     (o_best_ask),
        .o_result_ready (result_ready)
    );

endmodule

//--- rtl/quote_collector.sv
// result collector that picks the stock book that completed and holds its
// status and quotes through the acknowledge phase
`include "order_book_macros.svh"

module quote_collector (
    input  logic                        i_clk,
    input  logic                        i_reset_n,
    input  logic [`OB_NUM_STOCKS-1:0]   i_done,
    input  order_book_pkg::status_t     i_status   [`OB_NUM_STOCKS],
    input  order_book_pkg::price_t      i_best_bid [`OB_NUM_STOCKS],
    input  order_book_pkg::price_t      i_best_ask [`OB_NUM_STOCKS],
    input  logic                        i_bad_op,
    input  order_book_pkg::stock_id_t   i_sel_stock,
    output order_book_pkg::status_t     o_status,
    output order_book_pkg::price_t      o_best_bid,
    output order_book_pkg::price_t      o_best_ask,
    output logic                        o_result_ready
);

    logic                       sel_hit;
    order_book_pkg::status_t    sel_status;
    order_book_pkg::price_t     sel_bid;
    order_book_pkg::price_t     sel_ask;

    // a bad op reports the untouched quotes of the latched stock
    always_comb begin
        sel_hit    = i_bad_op;
        sel_status = order_book_pkg::BAD_OP;
        sel_bid    = i_best_bid[i_sel_stock];
        sel_ask    = i_best_ask[i_sel_stock];
        for (int s = 0; s < `OB_NUM_STOCKS; s++) begin
            if (i_done[s]) begin
                sel_hit    = 1'b1;
                sel_status = i_status[s];
                sel_bid    = i_best_bid[s];
                sel_ask    = i_best_ask[s];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            o_status       <= order_book_pkg::OK;
            o_best_bid     <= '0;
            o_best_ask     <= '1;
            o_result_ready <= 1'b0;
        end else begin
            o_result_ready <= sel_hit;
            if (sel_hit) begin
                o_status   <= sel_status;
                o_best_bid <= sel_bid;
                o_best_ask <= sel_ask;
            end
        end
    end

endmodule

//--- rtl/stock_book.sv
// bid and ask entry storage for one stock
// add, cancel and execute handling plus combinational best prices
`include "order_book_macros.svh"

module stock_book #(
    parameter int DEPTH = `OB_BOOK_DEPTH
) (
    input  logic                        i_clk,
    input  logic                        i_reset_n,
    input  logic                        i_cmd_valid,
    input  order_book_pkg::order_op_t   i_cmd_op,
    input  order_book_pkg::side_t       i_cmd_side,
    input  order_book_pkg::order_id_t   i_cmd_id,
    input  order_book_pkg::price_t      i_cmd_price,
    input  order_book_pkg::qty_t        i_cmd_qty,
    output logic                        o_done,
    output order_book_pkg::status_t     o_status,
    output order_book_pkg::price_t      o_best_bid,
    output order_book_pkg::price_t      o_best_ask
);

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // first index is the side: SELL rows are asks, BUY rows are bids
    logic                       valid_q [2][DEPTH];
    order_book_pkg::order_id_t  id_q    [2][DEPTH];
    order_book_pkg::price_t     price_q [2][DEPTH];
    order_book_pkg::qty_t       qty_q   [2][DEPTH];

    logic                       free_found;
    logic [IDX_W-1:0]           free_idx;
    logic                       hit_found;
    logic [IDX_W-1:0]           hit_idx;
    order_book_pkg::qty_t       hit_qty;
    order_book_pkg::qty_t       remain_qty;

    // search the addressed side; the downward loop leaves the lowest free slot
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        hit_found  = 1'b0;
        hit_idx    = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!valid_q[i_cmd_side][i]) begin
                free_found = 1'b1;
                free_idx   = IDX_W'(i);
            end
            if (valid_q[i_cmd_side][i] && id_q[i_cmd_side][i] == i_cmd_id) begin
                hit_found = 1'b1;
                hit_idx   = IDX_W'(i);
            end
        end
    end

    assign hit_qty    = qty_q[i_cmd_side][hit_idx];
    assign remain_qty = hit_qty - i_cmd_qty;

    // valid bits and the done strobe
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            o_done <= 1'b0;
            for (int s = 0; s < 2; s++) begin
                for (int i = 0; i < DEPTH; i++) begin
                    valid_q[s][i] <= 1'b0;
                end
            end
        end else begin
            o_done <= i_cmd_valid;
            if (i_cmd_valid) begin
                case (i_cmd_op)
                    order_book_pkg::ADD: begin
                        if (free_found) begin
                            valid_q[i_cmd_side][free_idx] <= 1'b1;
                        end
                    end
                    order_book_pkg::CANCEL: begin
                        if (hit_found) begin
                            valid_q[i_cmd_side][hit_idx] <= 1'b0;
                        end
                    end
                    order_book_pkg::EXECUTE: begin
                        if (hit_found && i_cmd_qty <= hit_qty && remain_qty == '0) begin
                            valid_q[i_cmd_side][hit_idx] <= 1'b0;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // entry payload and status
    always_ff @(posedge i_clk) begin
        if (i_cmd_valid) begin
            o_status <= order_book_pkg::OK;
            case (i_cmd_op)
                order_book_pkg::ADD: begin
                    if (free_found) begin
                        id_q[i_cmd_side][free_idx]    <= i_cmd_id;
                        price_q[i_cmd_side][free_idx] <= i_cmd_price;
                        qty_q[i_cmd_side][free_idx]   <= i_cmd_qty;
                    end else begin
                        o_status <= order_book_pkg::BOOK_FULL;
                    end
                end
                order_book_pkg::CANCEL: begin
                    if (!hit_found) o_status <= order_book_pkg::NOT_FOUND;
                end
                order_book_pkg::EXECUTE: begin
                    if (!hit_found) begin
                        o_status <= order_book_pkg::NOT_FOUND;
                    end else if (i_cmd_qty > hit_qty) begin
                        o_status <= order_book_pkg::OVERFILL;
                    end else begin
                        qty_q[i_cmd_side][hit_idx] <= remain_qty;
                    end
                end
                default: o_status <= order_book_pkg::BAD_OP;
            endcase
        end
    end

    // best bid is the highest buy price, best ask the lowest sell price
    always_comb begin
        o_best_bid = '0;
        o_best_ask = '1;
        for (int i = 0; i < DEPTH; i++) begin
            if (valid_q[order_book_pkg::BUY][i]
                    && price_q[order_book_pkg::BUY][i] > o_best_bid) begin
                o_best_bid = price_q[order_book_pkg::BUY][i];
            end
            if (valid_q[order_book_pkg::SELL][i]
                    && price_q[order_book_pkg::SELL][i] < o_best_ask) begin
                o_best_ask = price_q[order_book_pkg::SELL][i];
            end
        end
    end

endmodule

//--- rtl/order_dispatch.sv
// order dispatcher with the host four-phase handshake FSM
// latches one order and issues a one-cycle command to a stock book
`include "order_book_macros.svh"

module order_dispatch (
    input  logic                        i_clk,
    input  logic                        i_reset_n,
    input  logic                        i_req,
    input  order_book_pkg::order_op_t   i_op,
    input  order_book_pkg::side_t       i_side,
    input  order_book_pkg::stock_id_t   i_stock,
    input  order_book_pkg::order_id_t   i_id,
    input  order_book_pkg::price_t      i_price,
    input  order_book_pkg::qty_t        i_qty,
    input  logic                        i_result_ready,
    output logic                        o_ack,
    output logic [`OB_NUM_STOCKS-1:0]   o_cmd_valid,
    output order_book_pkg::order_op_t   o_cmd_op,
    output order_book_pkg::side_t       o_cmd_side,
    output order_book_pkg::order_id_t   o_cmd_id,
    output order_book_pkg::price_t      o_cmd_price,
    output order_book_pkg::qty_t        o_cmd_qty,
    output logic                        o_bad_op,
    output order_book_pkg::stock_id_t   o_sel_stock
);

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT,
        ACK
    } state_t;

    state_t state_q;
    logic   cmd_bad;

    // opcode 3 never reaches a stock book
    assign cmd_bad = !(o_cmd_op inside {order_book_pkg::ADD, order_book_pkg::CANCEL,
                                        order_book_pkg::EXECUTE});

    // order fields are captured on the accepting edge only
    always_ff @(posedge i_clk) begin
        if (state_q == IDLE && i_req) begin
            o_cmd_op    <= i_op;
            o_cmd_side  <= i_side;
            o_cmd_id    <= i_id;
            o_cmd_price <= i_price;
            o_cmd_qty   <= i_qty;
            o_sel_stock <= i_stock;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state_q  <= IDLE;
            o_bad_op <= 1'b0;
        end else begin
            // bad op flag lines up with the done pulse of a real command
            o_bad_op <= (state_q == ISSUE) && cmd_bad;
            case (state_q)
                IDLE:    if (i_req) state_q <= ISSUE;
                ISSUE:   state_q <= WAIT;
                WAIT:    if (i_result_ready) state_q <= ACK;
                ACK:     if (!i_req) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // one-hot command strobe for the latched stock
    always_comb begin
        o_cmd_valid = '0;
        if (state_q == ISSUE && !cmd_bad) begin
            o_cmd_valid[o_sel_stock] = 1'b1;
        end
    end

    assign o_ack = (state_q == ACK);

endmodule

//--- rtl/order_book_pkg.sv
// field types and the opcode, side and status encodings of the order book
`include "order_book_macros.svh"

package order_book_pkg;

    typedef logic [$clog2(`OB_NUM_STOCKS)-1:0] stock_id_t;
    typedef logic [`OB_PRICE_W-1:0] price_t;
    typedef logic [`OB_QTY_W-1:0] qty_t;
    typedef logic [`OB_ID_W-1:0] order_id_t;

    // code 3 is not an order and is rejected as BAD_OP
    typedef enum logic [1:0] {
        ADD     = 2'd0,
        CANCEL  = 2'd1,
        EXECUTE = 2'd2
    } order_op_t;

    // sell orders rest on the ask side, buy orders on the bid side
    typedef enum logic {
        SELL = 1'b0,
        BUY  = 1'b1
    } side_t;

    typedef enum logic [2:0] {
        OK        = 3'd0,
        NOT_FOUND = 3'd1,
        BOOK_FULL = 3'd2,
        // requested quantity above the resting quantity
        OVERFILL  = 3'd3,
        BAD_OP    = 3'd4
    } status_t;

endpackage

//--- include/order_book_macros.svh
// sizing constants for the order book
// stock count, per-side depth and order field widths
`ifndef ORDER_BOOK_MACROS_SVH
`define ORDER_BOOK_MACROS_SVH

// number of stocks served by one book
`define OB_NUM_STOCKS 4

// resting orders per side per stock
`define OB_BOOK_DEPTH 4

// order field widths in bits
`define OB_PRICE_W 32

`define OB_QTY_W 16

`define OB_ID_W 32

`endif
